// File: build.f
+incdir+common
common/audio_pkg.sv
common/display_pkg.sv
hw/spectrum/isqrt.sv
hw/spectrum/spectrum_magnitude.sv
hw/histogram_ram.sv
hw/display/column_gradient.sv
hw/spectrum_display_top.sv
tests/spectrum_tb.sv

// File: common/audio_pkg.sv
// Audio side types
// FFT samples, scaled parts, squares, magnitudes and the magnitude FSM

`default_nettype none

`include "spectrum_defs.svh"

package audio_pkg;

  // Scaled part width, squares and roots follow from it
  localparam int SCALED_W = 14;
  localparam int SQUARE_W = 2 * SCALED_W;
  localparam int MAG_W    = (SQUARE_W + 1) / 2;

  // Raw FFT outputs
  typedef logic signed [`SPEC_FFT_W-1:0] fft_sample_t;
  typedef logic [`SPEC_IDX_W-1:0]        fft_index_t;

  // After shift and truncation
  typedef logic signed [SCALED_W-1:0] scaled_t;

  // Sum of squares, unsigned
  typedef logic [SQUARE_W-1:0] square_t;

  // Integer square root result
  typedef logic [MAG_W-1:0] magnitude_t;

  typedef logic [`SPEC_SHIFT_W-1:0] shift_t;

  // Per-bin sequencing
  typedef enum logic [1:0] {
    IDLE,
    SQUARE,
    SUM,
    ROOT
  } mag_state_t;

endpackage

`default_nettype wire

// File: common/display_pkg.sv
// Display side types
// Histogram address, bar height, screen row and pixel colour

`default_nettype none

`include "spectrum_defs.svh"

package display_pkg;

  localparam int COORD_W = 10;
  localparam int CHAN_W  = 8;

  typedef logic [`SPEC_BINS_W-1:0]   bin_addr_t;
  typedef logic [`SPEC_HEIGHT_W-1:0] height_t;
  typedef logic [COORD_W-1:0]        coord_t;

  // Red in the top byte, then green, then blue
  typedef logic [3*CHAN_W-1:0] pixel_t;

  // Bar colours
  localparam pixel_t PIXEL_RED   = {{CHAN_W{1'b1}}, {CHAN_W{1'b0}}, {CHAN_W{1'b0}}};
  localparam pixel_t PIXEL_GREEN = {{CHAN_W{1'b0}}, {CHAN_W{1'b1}}, {CHAN_W{1'b0}}};
  localparam pixel_t PIXEL_BLACK = '0;

endpackage

`default_nettype wire

// File: common/spectrum_defs.svh
// Spectrum back end width definitions
// Shared sizes for the FFT stream, the histogram and the bar heights

`ifndef SPEC_DEFS_SVH
`define SPEC_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// FFT stream
////////////////////////////////////////////////////////////////////////////

// Real and imaginary part width from the streaming FFT
`define SPEC_FFT_W 23

// Bin index width, 16384 point transform
`define SPEC_IDX_W 14

// Scale select, right shift amount
`define SPEC_SHIFT_W 4

////////////////////////////////////////////////////////////////////////////
// Histogram and display
////////////////////////////////////////////////////////////////////////////

// Histogram address, 1024 displayed bins
`define SPEC_BINS_W 10

// Bar height width
`define SPEC_HEIGHT_W 10

`endif

// File: hw/display/column_gradient.sv
// Column gradient renderer
// Fetches a column's bar height and colours the pixel by its row

`default_nettype none

module column_gradient
  import display_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  bin_addr_t column,
  input  coord_t    row,
  output bin_addr_t rd_addr,
  input  height_t   rd_height,
  output pixel_t    pixel
);

  coord_t  row_q;
  height_t half;

  // Column is the histogram address
  assign rd_addr = column;

  // Split point of the bar
  assign half = rd_height >> 1;

  // Row lines up with the RAM read
  always_ff @(posedge clk) begin
    row_q <= row;
  end

  // Pixel register
  always_ff @(posedge clk) begin
    if (reset) begin
      pixel <= PIXEL_BLACK;
    end else if (row_q > half) begin
      pixel <= PIXEL_RED;
    end else if (row_q < half) begin
      pixel <= PIXEL_GREEN;
    end else begin
      pixel <= PIXEL_BLACK;
    end
  end

endmodule

`default_nettype wire

// File: hw/histogram_ram.sv
// Histogram memory
// One bar height per bin, single write port and registered read port

`default_nettype none

`include "spectrum_defs.svh"

module histogram_ram
  import display_pkg::*;
(
  input  logic      clk,
  input  logic      we,
  input  bin_addr_t wr_addr,
  input  height_t   wr_height,
  input  bin_addr_t rd_addr,
  output height_t   rd_height
);

  localparam int DEPTH = 1 << `SPEC_BINS_W;

  height_t mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_addr] <= wr_height;
    end
  end

  // Registered read for block RAM
  always_ff @(posedge clk) begin
    rd_height <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: hw/spectrum/isqrt.sv
// Integer square root
// Bit-serial, one result bit per cycle from the top bit down

`default_nettype none

module isqrt #(
  parameter  int NBITS = 28,
  localparam int MBITS = (NBITS + 1) / 2
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  logic [NBITS-1:0] data,
  output logic [MBITS-1:0] answer,
  output logic             done
);

  localparam int CNT_W = $clog2(MBITS + 1);

  logic                 busy;
  logic [CNT_W-1:0]     bit_idx;
  logic [MBITS-1:0]     trial;
  logic [2*MBITS-1:0]   trial_sq;
  logic [2*MBITS-1:0]   answer_sq;
  logic [2*MBITS-1:0]   data_ext;

  // Candidate with the current bit set
  assign trial     = answer | (MBITS'(1) << bit_idx);
  assign trial_sq  = trial * trial;
  assign answer_sq = answer * answer;
  assign data_ext  = (2*MBITS)'(data);

  assign done = ~busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      bit_idx <= '0;
    end else if (busy) begin
      if (bit_idx == '0) busy <= 1'b0;
      else bit_idx <= bit_idx - 1'b1;
    end else if (start) begin
      busy    <= 1'b1;
      bit_idx <= CNT_W'(MBITS - 1);
    end
  end

  // Result bits, no reset
  always_ff @(posedge clk) begin
    if (busy) begin
      // Keep the bit if it does not overshoot
      if (trial_sq <= data_ext) answer <= trial;
    end else if (start) begin
      answer <= '0;
    end
  end

  // Finished root never overshoots the radicand
  a_root_bound: assert property (@(posedge clk) disable iff (reset)
    $rose(done) |-> (answer_sq <= data_ext));

endmodule

`default_nettype wire

// File: hw/spectrum/spectrum_magnitude.sv
// Spectrum magnitude
// Scales each FFT bin, squares and sums the parts, runs the square root
// and writes the saturated height into the histogram

`default_nettype none

`include "spectrum_defs.svh"

module spectrum_magnitude
  import audio_pkg::*, display_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  fft_sample_t fft_re,
  input  fft_sample_t fft_im,
  input  fft_index_t  fft_index,
  input  logic        fft_ready,
  input  shift_t      shift,
  output logic        root_start,
  output square_t     root_data,
  input  magnitude_t  root,
  input  logic        root_done,
  output logic        hist_we,
  output bin_addr_t   hist_addr,
  output height_t     hist_height
);

  // Largest bar the display can show
  localparam magnitude_t HEIGHT_LIMIT = magnitude_t'({`SPEC_HEIGHT_W{1'b1}});

  mag_state_t state;
  scaled_t    re_scaled;
  scaled_t    im_scaled;
  square_t    re_square;
  square_t    im_square;
  logic       in_range;

  // Arithmetic shift then keep the low bits
  assign re_scaled = scaled_t'(fft_re >>> shift);
  assign im_scaled = scaled_t'(fft_im >>> shift);

  // Only the lower 1024 bins are displayed
  assign in_range = (fft_index[`SPEC_IDX_W-1:`SPEC_BINS_W] == '0);

  // Sum is registered, root starts on the next cycle
  assign root_start = (state == SUM);

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      hist_we <= 1'b0;
    end else begin
      hist_we <= 1'b0;
      case (state)
        // Strobes outside IDLE are dropped
        IDLE:   if (fft_ready && in_range) state <= SQUARE;
        SQUARE: state <= SUM;
        SUM:    state <= ROOT;
        ROOT: begin
          if (root_done) begin
            state   <= IDLE;
            hist_we <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Capture squares on the strobe cycle
    if (state == IDLE && fft_ready) begin
      re_square <= re_scaled * re_scaled;
      im_square <= im_scaled * im_scaled;
      hist_addr <= fft_index[`SPEC_BINS_W-1:0];
    end
    // Held stable while the root runs
    if (state == SQUARE) begin
      root_data <= re_square + im_square;
    end
    // Saturate instead of wrapping
    if (state == ROOT && root_done) begin
      hist_height <= (root > HEIGHT_LIMIT) ? height_t'(HEIGHT_LIMIT) : height_t'(root);
    end
  end

  // Root unit must be idle when a new root is requested
  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    root_start |-> root_done);

  // Single write per bin
  a_we_pulse: assert property (@(posedge clk) disable iff (reset)
    hist_we |=> !hist_we);

endmodule

`default_nettype wire

// File: hw/spectrum_display_top.sv
// Spectrum display top
// Magnitude path, square root, histogram and column renderer

`default_nettype none

module spectrum_display_top
  import audio_pkg::*, display_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  fft_sample_t fft_re,
  input  fft_sample_t fft_im,
  input  fft_index_t  fft_index,
  input  logic        fft_ready,
  input  shift_t      shift,
  input  bin_addr_t   column,
  input  coord_t      row,
  output pixel_t      pixel
);

  // Magnitude to root unit
  logic       root_start;
  square_t    root_data;
  magnitude_t root;
  logic       root_done;

  // Histogram write side
  logic       hist_we;
  bin_addr_t  hist_addr;
  height_t    hist_height;

  // Histogram read side
  bin_addr_t  rd_addr;
  height_t    rd_height;

  spectrum_magnitude u_magnitude (
    .clk         (clk),
    .reset       (reset),
    .fft_re      (fft_re),
    .fft_im      (fft_im),
    .fft_index   (fft_index),
    .fft_ready   (fft_ready),
    .shift       (shift),
    .root_start  (root_start),
    .root_data   (root_data),
    .root        (root),
    .root_done   (root_done),
    .hist_we     (hist_we),
    .hist_addr   (hist_addr),
    .hist_height (hist_height)
  );

  isqrt #(.NBITS(SQUARE_W)) u_isqrt (
    .clk    (clk),
    .reset  (reset),
    .start  (root_start),
    .data   (root_data),
    .answer (root),
    .done   (root_done)
  );

  histogram_ram u_histogram (
    .clk       (clk),
    .we        (hist_we),
    .wr_addr   (hist_addr),
    .wr_height (hist_height),
    .rd_addr   (rd_addr),
    .rd_height (rd_height)
  );

  column_gradient u_renderer (
    .clk       (clk),
    .reset     (reset),
    .column    (column),
    .row       (row),
    .rd_addr   (rd_addr),
    .rd_height (rd_height),
    .pixel     (pixel)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the spectrum display simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module spectrum_tb -f build.f -o spectrum_sim
./obj_dir/spectrum_sim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tests/spectrum_tb.sv
// Spectrum display testbench
// Writes FFT bins into the DUT, probes rendered pixels and compares them
// against a reference model of the magnitude and colour rules

`default_nettype none

`include "spectrum_defs.svh"

module spectrum_tb
  import audio_pkg::*, display_pkg::*;
();

  localparam int DEPTH      = 1 << `SPEC_BINS_W;
  localparam int NUM_BINS   = 50;
  localparam int NUM_PROBES = 90;
  // Each bin or probe needs at most 25 cycles
  // Margin covers reset and drain
  localparam int TIMEOUT    = (NUM_BINS + NUM_PROBES) * 25 + 500;

  logic        clk;
  logic        reset;
  fft_sample_t fft_re;
  fft_sample_t fft_im;
  fft_index_t  fft_index;
  logic        fft_ready;
  shift_t      shift;
  bin_addr_t   column;
  coord_t      row;
  pixel_t      pixel;

  // Model of the histogram contents
  height_t   model_h [DEPTH];
  bin_addr_t rand_cols [$];

  // Probe pipeline lines up with the two renderer stages
  logic      probe_valid = 1'b0;
  pixel_t    probe_exp;
  bin_addr_t probe_col;
  coord_t    probe_row;
  logic      valid_d1 = 1'b0;
  logic      valid_d2 = 1'b0;
  pixel_t    exp_d1;
  pixel_t    exp_d2;
  bin_addr_t col_d1;
  bin_addr_t col_d2;
  coord_t    row_d1;
  coord_t    row_d2;

  int    errors = 0;
  int    check_count = 0;
  int    tests_done = 0;
  int    errors_at_start;
  int    checks_at_start;
  int    cycle_count = 0;
  string test_name;

  spectrum_display_top DUT (
    .clk       (clk),
    .reset     (reset),
    .fft_re    (fft_re),
    .fft_im    (fft_im),
    .fft_index (fft_index),
    .fft_ready (fft_ready),
    .shift     (shift),
    .column    (column),
    .row       (row),
    .pixel     (pixel)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Keep the low 14 bits as a signed value
  function automatic int wrap14(input int v);
    int w;
    w = v & 32'h3fff;
    if (w >= 8192) w = w - 16384;
    return w;
  endfunction

  // Floor of the root of the sum of squares clipped to 1023
  function automatic height_t expected_height(input fft_sample_t re, input fft_sample_t im,
                                              input shift_t sh);
    int     re_v;
    int     im_v;
    longint sum;
    longint r;
    re_v = re;
    im_v = im;
    re_v = wrap14(re_v >>> sh);
    im_v = wrap14(im_v >>> sh);
    sum  = longint'(re_v) * re_v + longint'(im_v) * im_v;
    r = 0;
    while ((r + 1) * (r + 1) <= sum) r = r + 1;
    if (r > 1023) return height_t'(1023);
    return height_t'(r);
  endfunction

  // Green below half the bar, red above, black on the split row
  function automatic pixel_t expected_pixel(input height_t h, input coord_t r);
    int half_h;
    half_h = h / 2;
    if (int'(r) == half_h) return 24'h000000;
    else if (int'(r) < half_h) return 24'h00ff00;
    else return 24'hff0000;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_pixel(input pixel_t expected, input pixel_t actual,
                             input bin_addr_t col, input coord_t r);
    check_count++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] pixel: expected %h, got %h at column %0d row %0d",
               expected, actual, col, r);
    end
  endtask

  // One strobe then a wait until the histogram holds the result
  task automatic write_bin(input fft_sample_t re, input fft_sample_t im,
                           input fft_index_t idx, input shift_t sh);
    fft_re    = re;
    fft_im    = im;
    fft_index = idx;
    shift     = sh;
    fft_ready = 1'b1;
    @(negedge clk);
    fft_ready = 1'b0;
    repeat (20) @(negedge clk);
    if (idx < fft_index_t'(DEPTH)) model_h[idx[`SPEC_BINS_W-1:0]] = expected_height(re, im, sh);
  endtask

  task automatic probe_pixel(input bin_addr_t col, input coord_t r);
    column      = col;
    row         = r;
    probe_exp   = expected_pixel(model_h[col], r);
    probe_col   = col;
    probe_row   = r;
    probe_valid = 1'b1;
    @(negedge clk);
    probe_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    checks_at_start = check_count;
  endtask

  task automatic finish_test;
    repeat (3) @(negedge clk);
    tests_done++;
    $display("%s: %0d checks, %0d errors", test_name,
             check_count - checks_at_start, errors - errors_at_start);
  endtask

  always @(posedge clk) begin
    valid_d1 <= probe_valid;
    valid_d2 <= valid_d1;
    exp_d1   <= probe_exp;
    exp_d2   <= exp_d1;
    col_d1   <= probe_col;
    col_d2   <= col_d1;
    row_d1   <= probe_row;
    row_d2   <= row_d1;
  end

  // Pixel is settled by the falling edge
  always @(negedge clk) begin
    if (valid_d2) check_pixel(exp_d2, pixel, col_d2, row_d2);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bin_addr_t col;
    coord_t    r;
    void'($urandom(32'h18be));
    clk       = 1'b0;
    reset     = 1'b1;
    fft_re    = '0;
    fft_im    = '0;
    fft_index = '0;
    fft_ready = 1'b0;
    shift     = '0;
    column    = '0;
    row       = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // 3-4-5 pairs with heights 50 and 500
    start_test("basic_magnitude");
    write_bin(fft_sample_t'(30), fft_sample_t'(40), fft_index_t'(5), shift_t'(0));
    write_bin(fft_sample_t'(-300), fft_sample_t'(400), fft_index_t'(6), shift_t'(0));
    for (int i = 24; i <= 26; i++) probe_pixel(bin_addr_t'(5), coord_t'(i));
    for (int i = 249; i <= 251; i++) probe_pixel(bin_addr_t'(6), coord_t'(i));
    finish_test();

    // Same parts at three shifts
    start_test("scaling");
    write_bin(fft_sample_t'(600), fft_sample_t'(-800), fft_index_t'(20), shift_t'(0));
    write_bin(fft_sample_t'(600), fft_sample_t'(-800), fft_index_t'(21), shift_t'(2));
    write_bin(fft_sample_t'(600), fft_sample_t'(-800), fft_index_t'(22), shift_t'(5));
    for (int c = 20; c <= 22; c++) begin
      for (int d = -1; d <= 1; d++) begin
        probe_pixel(bin_addr_t'(c), coord_t'(int'(model_h[c] / 2) + d));
      end
    end
    finish_test();

    // Index 1031 aliases column 7 but must be dropped
    start_test("index_filter");
    write_bin(fft_sample_t'(60), fft_sample_t'(80), fft_index_t'(7), shift_t'(0));
    write_bin(fft_sample_t'(600), fft_sample_t'(800), fft_index_t'(1031), shift_t'(0));
    for (int i = 49; i <= 51; i++) probe_pixel(bin_addr_t'(7), coord_t'(i));
    finish_test();

    start_test("saturation");
    write_bin(fft_sample_t'(8000), fft_sample_t'(-8000), fft_index_t'(100), shift_t'(0));
    probe_pixel(bin_addr_t'(100), coord_t'(0));
    probe_pixel(bin_addr_t'(100), coord_t'(255));
    probe_pixel(bin_addr_t'(100), coord_t'(510));
    probe_pixel(bin_addr_t'(100), coord_t'(511));
    probe_pixel(bin_addr_t'(100), coord_t'(512));
    probe_pixel(bin_addr_t'(100), coord_t'(1023));
    finish_test();

    // Second strobe to the same bin arrives while the root is running
    start_test("dropped_strobe");
    fft_re    = fft_sample_t'(120);
    fft_im    = fft_sample_t'(160);
    fft_index = fft_index_t'(300);
    shift     = shift_t'(0);
    fft_ready = 1'b1;
    @(negedge clk);
    fft_ready = 1'b0;
    repeat (4) @(negedge clk);
    // Would saturate the bar if it were taken
    fft_re    = fft_sample_t'(900);
    fft_im    = fft_sample_t'(1200);
    fft_index = fft_index_t'(300);
    fft_ready = 1'b1;
    @(negedge clk);
    fft_ready = 1'b0;
    repeat (20) @(negedge clk);
    model_h[300] = expected_height(fft_sample_t'(120), fft_sample_t'(160), shift_t'(0));
    for (int i = 99; i <= 101; i++) probe_pixel(bin_addr_t'(300), coord_t'(i));
    finish_test();

    start_test("random");
    for (int i = 0; i < 40; i++) begin
      col = bin_addr_t'($urandom);
      write_bin(fft_sample_t'($urandom), fft_sample_t'($urandom), fft_index_t'(col),
                shift_t'($urandom));
      rand_cols.push_back(col);
    end
    for (int i = 0; i < 60; i++) begin
      col = rand_cols[$urandom_range(0, rand_cols.size() - 1)];
      // Hit the split row now and then
      if ($urandom_range(0, 3) == 0) r = coord_t'(model_h[col] >> 1);
      else r = coord_t'($urandom_range(0, 1023));
      probe_pixel(col, r);
    end
    finish_test();

    $display("tests %0d, checks %0d, errors %0d", tests_done, check_count, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
